//--- Makefile
# Verilator flow for the pipelined MIPS subset
VERILATOR ?= verilator
TOP       ?= mips_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP) $(VFLAGS)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) $(VFLAGS)

# the verdict comes from the log, not from the exit status of the pipe
sim: $(BUILD_DIR)/V$(TOP) program.hex
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- build.f
logic/mips_pkg.sv
logic/pipe_if.sv
logic/fetch_unit.sv
logic/control_decoder.sv
logic/register_file.sv
logic/decode_unit.sv
logic/execute_unit.sv
logic/memory_unit.sv
logic/mips.sv
dv/mips_chk.sv
dv/mips_tb.sv

//--- dv/mips_chk.sv
`timescale 1ns/1ps

module mips_chk (
	input logic            clk,
	input logic            rst,
	input logic            mem_read,
	input logic            mem_write,
	input mips_pkg::word_t addr,
	input mips_pkg::word_t out1,
	input mips_pkg::word_t out2
);
	// failure tally
	int fail_count = 0;

	// single data port, load and store never in the same cycle
	a_one_access: assert property (@(posedge clk) disable iff (rst) !(mem_read && mem_write))
		else begin
			$error("load and store active in the same cycle");
			fail_count++;
		end

	// word addressed memory, low two bits must be clear on stores
	a_store_align: assert property (@(posedge clk) disable iff (rst)
		mem_write |-> (addr[1:0] == 2'b00))
		else begin
			$error("store address 0x%08h is not word aligned", addr);
			fail_count++;
		end

	// observation words come out of reset cleared
	a_clear_after_rst: assert property (@(posedge clk) $fell(rst) |-> (out1 == '0 && out2 == '0))
		else begin
			$error("observation words not zero right after reset");
			fail_count++;
		end

endmodule

bind memory_unit mips_chk u_chk (
	.clk       (clk),
	.rst       (rst),
	.mem_read  (ex_mem.mem_read),
	.mem_write (ex_mem.mem_write),
	.addr      (ex_mem.alu_result),
	.out1      (out1),
	.out2      (out2)
);

//--- dv/mips_tb.sv
`timescale 1ns/1ps

module mips_tb;
	import mips_pkg::*;

	localparam int RESET_CYCLES     = 16;
	localparam int CYCLES_PER_INSTR = 40;
	// drain time for stores still in the five stages
	localparam int PIPE_DEPTH       = 5;
	// model gives up here when no self-jump shows up
	localparam int MAX_STEPS        = 10000;

	logic  clk = 1'b0;
	logic  rst = 1'b1;
	word_t out1;
	word_t out2;

	// ############################################################
	// reference model state
	// ############################################################
	word_t prog [IMEM_WORDS];
	word_t exp1_q [$];
	word_t exp2_q [$];
	word_t final1;
	word_t final2;
	int    exp1_n = 0;
	int    exp2_n = 0;
	int    model_steps = 0;
	// taken branches and jumps, one bubble each
	int    model_redirects = 0;
	logic  model_done = 1'b0;
	logic  model_ready = 1'b0;

	// changes seen on the dut side
	int seen1 = 0;
	int seen2 = 0;
	int error_count = 0;

	mips uut (
		.clk  (clk),
		.rst  (rst),
		.out1 (out1),
		.out2 (out2)
	);

	always #20 clk = ~clk;

	task automatic stop_on_failure();
		$display("test failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t expected);
		if (got !== expected) begin
			error_count++;
			$display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, expected);
			stop_on_failure();
		end
	endtask

	task automatic check_count(input string name, input int got, input int expected);
		if (got != expected) begin
			error_count++;
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, expected);
			stop_on_failure();
		end
	endtask

	// sequential isa interpreter, no delay slot, stops at a self-jump
	function automatic int run_model();
		word_t              rf [32];
		word_t              dm [DMEM_WORDS];
		word_t              pc;
		word_t              nxt;
		word_t              ins;
		word_t              simm;
		word_t              addr;
		opcode_t            op;
		funct_t             fn;
		reg_idx_t           rs;
		reg_idx_t           rt;
		reg_idx_t           rd;
		logic [DMEM_AW-1:0] widx;
		int                 steps;
		int                 jumps;
		for (int i = 0; i < IMEM_WORDS; i++) begin
			prog[i] = '0;
		end
		for (int i = 0; i < 32; i++) begin
			rf[i] = '0;
		end
		for (int i = 0; i < DMEM_WORDS; i++) begin
			dm[i] = '0;
		end
		$readmemh(IMEM_FILE, prog);
		pc = '0;
		steps = 0;
		jumps = 0;
		while (!model_done && steps < MAX_STEPS) begin
			ins = prog[pc[IMEM_AW+1:2]];
			steps++;
			op   = opcode_t'(ins[31:26]);
			fn   = funct_t'(ins[5:0]);
			rs   = ins[25:21];
			rt   = ins[20:16];
			rd   = ins[15:11];
			simm = {{16{ins[15]}}, ins[15:0]};
			addr = rf[rs] + simm;
			widx = addr[DMEM_AW+1:2];
			nxt  = pc + 32'd4;
			case (op)
				OP_RTYPE: begin
					case (fn)
						FN_ADD: rf[rd] = rf[rs] + rf[rt];
						FN_SUB: rf[rd] = rf[rs] - rf[rt];
						FN_AND: rf[rd] = rf[rs] & rf[rt];
						FN_OR:  rf[rd] = rf[rs] | rf[rt];
						FN_SLT: rf[rd] = ($signed(rf[rs]) < $signed(rf[rt])) ? 32'd1 : 32'd0;
						FN_SLL: rf[rd] = rf[rt] << ins[10:6];
						FN_JR: begin
							nxt = rf[rs];
							jumps++;
						end
						default: ;
					endcase
				end
				OP_ADDI: rf[rt] = addr;
				OP_LW:   rf[rt] = dm[widx];
				OP_SW: begin
					// only value changes are visible on out1 and out2
					if (widx == '0 && dm[widx] != rf[rt]) begin
						exp1_q.push_back(rf[rt]);
					end
					if (widx == DMEM_AW'(1) && dm[widx] != rf[rt]) begin
						exp2_q.push_back(rf[rt]);
					end
					dm[widx] = rf[rt];
				end
				OP_BEQ: begin
					if (rf[rs] == rf[rt]) begin
						nxt = pc + 32'd4 + (simm << 2);
						jumps++;
					end
				end
				OP_BNE: begin
					if (rf[rs] != rf[rt]) begin
						nxt = pc + 32'd4 + (simm << 2);
						jumps++;
					end
				end
				OP_J: begin
					nxt = {nxt[31:28], ins[25:0], 2'b00};
					jumps++;
					if (nxt == pc) model_done = 1'b1;
				end
				OP_JAL: begin
					rf[reg_idx_t'(LINK_REG)] = nxt;
					nxt = {nxt[31:28], ins[25:0], 2'b00};
					jumps++;
				end
				default: ;
			endcase
			rf[5'd0] = '0;
			pc = nxt;
		end
		final1 = dm[0];
		final2 = dm[1];
		exp1_n = exp1_q.size();
		exp2_n = exp2_q.size();
		model_redirects = jumps;
		return steps;
	endfunction

	// ############################################################
	// stimulus and verdict
	// ############################################################
	initial begin
		model_steps = run_model();
		model_ready = 1'b1;
		if (!model_done) begin
			$display("reference model found no self-jump within %0d steps", MAX_STEPS);
			stop_on_failure();
		end
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		// one fetch slot per instruction, one bubble per redirect
		repeat (model_steps + model_redirects + PIPE_DEPTH) @(posedge clk);
		// memory moves on the rising edge
		@(negedge clk);
		check_word("out1", out1, final1);
		check_word("out2", out2, final2);
		check_count("out1 changes", seen1, exp1_n);
		check_count("out2 changes", seen2, exp2_n);
		if (error_count == 0) begin
			$display("test passed");
			$finish;
		end else begin
			$display("%0d checks failed", error_count);
			stop_on_failure();
		end
	end

	// compare on the falling edge, memory moves on the rising one
	initial begin
		word_t prev1;
		word_t prev2;
		prev1 = '0;
		prev2 = '0;
		forever begin
			@(negedge clk);
			if (uut.u_memory.u_chk.fail_count != 0) begin
				$display("an assertion on the memory stage fired");
				stop_on_failure();
			end
			if (rst) begin
				check_word("out1", out1, '0);
				check_word("out2", out2, '0);
			end else begin
				if (out1 !== prev1) begin
					if (seen1 >= exp1_n) begin
						$display("out1 changed more often than the model predicts");
						stop_on_failure();
					end else begin
						check_word("out1", out1, exp1_q[seen1]);
						seen1++;
						prev1 = out1;
					end
				end
				if (out2 !== prev2) begin
					if (seen2 >= exp2_n) begin
						$display("out2 changed more often than the model predicts");
						stop_on_failure();
					end else begin
						check_word("out2", out2, exp2_q[seen2]);
						seen2++;
						prev2 = out2;
					end
				end
			end
		end
	end

	// watchdog, budget scales with the model's instruction count
	initial begin
		wait (model_ready);
		repeat (RESET_CYCLES + CYCLES_PER_INSTR * model_steps) @(posedge clk);
		$display("timeout, the program did not finish in %0d cycles",
			RESET_CYCLES + CYCLES_PER_INSTR * model_steps);
		stop_on_failure();
	end

endmodule

//--- logic/control_decoder.sv
`timescale 1ns/1ps

module control_decoder (
	input  mips_pkg::opcode_t  opcode,
	input  mips_pkg::funct_t   funct,
	output mips_pkg::alu_op_t  alu_op,
	output logic               use_imm,
	output logic               use_shamt,
	output mips_pkg::dst_sel_t dst_sel,
	output logic               mem_read,
	output logic               mem_write,
	output mips_pkg::wb_sel_t  wb_sel,
	output logic               reg_write,
	output mips_pkg::pc_sel_t  pc_sel,
	output logic               branch_eq,
	output logic               branch_ne
);
	import mips_pkg::*;

	always_comb begin
		// bubble defaults, no writes anywhere
		alu_op    = ALU_ADD;
		use_imm   = 1'b0;
		use_shamt = 1'b0;
		dst_sel   = DST_RT;
		mem_read  = 1'b0;
		mem_write = 1'b0;
		wb_sel    = WB_ALU;
		reg_write = 1'b0;
		pc_sel    = PC_SEQ;
		branch_eq = 1'b0;
		branch_ne = 1'b0;
		case (opcode)
			OP_RTYPE: begin
				dst_sel   = DST_RD;
				reg_write = 1'b1;
				case (funct)
					FN_ADD: alu_op = ALU_ADD;
					FN_SUB: alu_op = ALU_SUB;
					FN_AND: alu_op = ALU_AND;
					FN_OR:  alu_op = ALU_OR;
					FN_SLT: alu_op = ALU_SLT;
					FN_SLL: begin
						alu_op    = ALU_SLL;
						use_shamt = 1'b1;
					end
					// jr only steers the pc
					FN_JR: begin
						reg_write = 1'b0;
						pc_sel    = PC_REG;
					end
					default: reg_write = 1'b0;
				endcase
			end
			OP_ADDI: begin
				use_imm   = 1'b1;
				reg_write = 1'b1;
			end
			OP_LW: begin
				use_imm   = 1'b1;
				mem_read  = 1'b1;
				wb_sel    = WB_MEM;
				reg_write = 1'b1;
			end
			OP_SW: begin
				use_imm   = 1'b1;
				mem_write = 1'b1;
			end
			OP_BEQ: branch_eq = 1'b1;
			OP_BNE: branch_ne = 1'b1;
			OP_J:   pc_sel = PC_JUMP;
			// link pc + 4 into r31
			OP_JAL: begin
				pc_sel    = PC_JUMP;
				dst_sel   = DST_RA;
				wb_sel    = WB_LINK;
				reg_write = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

//--- logic/decode_unit.sv
`timescale 1ns/1ps

module decode_unit (
	input  logic            clk,
	input  logic            rst,
	input  mips_pkg::word_t instr,
	input  mips_pkg::word_t pc_plus4,
	output logic            redirect,
	output mips_pkg::word_t target,
	id_ex_if.src            id_ex,
	mem_wb_if.dst           mem_wb
);
	import mips_pkg::*;

	// instruction fields
	opcode_t            opcode;
	funct_t             funct;
	reg_idx_t           rs;
	reg_idx_t           rt;
	reg_idx_t           rd;
	logic [SHAMT_W-1:0] shamt;
	word_t              imm;

	// control
	alu_op_t  alu_op;
	logic     use_imm;
	logic     use_shamt;
	dst_sel_t dst_sel;
	logic     mem_read;
	logic     mem_write;
	wb_sel_t  wb_sel;
	logic     reg_write;
	pc_sel_t  pc_sel;
	logic     branch_eq;
	logic     branch_ne;

	word_t rs_val;
	word_t rt_val;
	word_t wb_data;
	word_t branch_target;
	word_t jump_target;
	logic  operands_equal;
	logic  branch_taken;

	assign opcode = opcode_t'(instr[31:26]);
	assign funct  = funct_t'(instr[5:0]);
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];
	assign shamt  = instr[10:6];
	// sign extend
	assign imm    = {{(XLEN-16){instr[15]}}, instr[15:0]};

	control_decoder u_ctrl (
		.opcode    (opcode),
		.funct     (funct),
		.alu_op    (alu_op),
		.use_imm   (use_imm),
		.use_shamt (use_shamt),
		.dst_sel   (dst_sel),
		.mem_read  (mem_read),
		.mem_write (mem_write),
		.wb_sel    (wb_sel),
		.reg_write (reg_write),
		.pc_sel    (pc_sel),
		.branch_eq (branch_eq),
		.branch_ne (branch_ne)
	);

	// ############################################################
	// writeback select, done here next to the register file
	// ############################################################
	always_comb begin
		case (mem_wb.wb_sel)
			WB_MEM:  wb_data = mem_wb.mem_data;
			WB_LINK: wb_data = mem_wb.pc_plus4;
			default: wb_data = mem_wb.alu_result;
		endcase
	end

	register_file u_rf (
		.clk     (clk),
		.rst     (rst),
		.we      (mem_wb.reg_write),
		.waddr   (mem_wb.dest),
		.wdata   (wb_data),
		.raddr_a (rs),
		.raddr_b (rt),
		.rdata_a (rs_val),
		.rdata_b (rt_val)
	);

	// ############################################################
	// branch and jump resolution
	// ############################################################
	assign operands_equal = (rs_val == rt_val);
	assign branch_taken   = (branch_eq & operands_equal) | (branch_ne & ~operands_equal);
	assign branch_target  = pc_plus4 + (imm << 2);
	// region bits come from the delay-free pc + 4
	assign jump_target    = {pc_plus4[XLEN-1:28], instr[25:0], 2'b00};
	assign redirect       = branch_taken | (pc_sel != PC_SEQ);

	always_comb begin
		case (pc_sel)
			PC_JUMP: target = jump_target;
			PC_REG:  target = rs_val;
			default: target = branch_target;
		endcase
	end

	// decode/execute register
	always_ff @(posedge clk) begin
		if (rst) begin
			id_ex.rs_val    <= '0;
			id_ex.rt_val    <= '0;
			id_ex.imm       <= '0;
			id_ex.shamt     <= '0;
			id_ex.rt        <= '0;
			id_ex.rd        <= '0;
			id_ex.alu_op    <= ALU_ADD;
			id_ex.use_imm   <= 1'b0;
			id_ex.use_shamt <= 1'b0;
			id_ex.dst_sel   <= DST_RT;
			id_ex.mem_read  <= 1'b0;
			id_ex.mem_write <= 1'b0;
			id_ex.wb_sel    <= WB_ALU;
			id_ex.reg_write <= 1'b0;
			id_ex.pc_plus4  <= '0;
		end else begin
			id_ex.rs_val    <= rs_val;
			id_ex.rt_val    <= rt_val;
			id_ex.imm       <= imm;
			id_ex.shamt     <= shamt;
			id_ex.rt        <= rt;
			id_ex.rd        <= rd;
			id_ex.alu_op    <= alu_op;
			id_ex.use_imm   <= use_imm;
			id_ex.use_shamt <= use_shamt;
			id_ex.dst_sel   <= dst_sel;
			id_ex.mem_read  <= mem_read;
			id_ex.mem_write <= mem_write;
			id_ex.wb_sel    <= wb_sel;
			id_ex.reg_write <= reg_write;
			id_ex.pc_plus4  <= pc_plus4;
		end
	end

endmodule

//--- logic/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
	input  logic  clk,
	input  logic  rst,
	id_ex_if.dst  id_ex,
	ex_mem_if.src ex_mem
);
	import mips_pkg::*;

	word_t    op_a;
	word_t    op_b;
	word_t    alu_result;
	reg_idx_t dest;

	// sll takes its amount from the shamt field, shifts rt
	assign op_a = id_ex.use_shamt ? XLEN'(id_ex.shamt) : id_ex.rs_val;
	assign op_b = id_ex.use_imm ? id_ex.imm : id_ex.rt_val;

	// ############################################################
	// alu
	// ############################################################
	always_comb begin
		case (id_ex.alu_op)
			ALU_SUB: alu_result = op_a - op_b;
			ALU_AND: alu_result = op_a & op_b;
			ALU_OR:  alu_result = op_a | op_b;
			// signed compare
			ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
			ALU_SLL: alu_result = op_b << op_a[SHAMT_W-1:0];
			default: alu_result = op_a + op_b;
		endcase
	end

	// destination register
	always_comb begin
		case (id_ex.dst_sel)
			DST_RD:  dest = id_ex.rd;
			DST_RA:  dest = reg_idx_t'(LINK_REG);
			default: dest = id_ex.rt;
		endcase
	end

	// execute/memory register
	always_ff @(posedge clk) begin
		if (rst) begin
			ex_mem.alu_result <= '0;
			ex_mem.store_data <= '0;
			ex_mem.dest       <= '0;
			ex_mem.mem_read   <= 1'b0;
			ex_mem.mem_write  <= 1'b0;
			ex_mem.wb_sel     <= WB_ALU;
			ex_mem.reg_write  <= 1'b0;
			ex_mem.pc_plus4   <= '0;
		end else begin
			ex_mem.alu_result <= alu_result;
			// sw data is always rt
			ex_mem.store_data <= id_ex.rt_val;
			ex_mem.dest       <= dest;
			ex_mem.mem_read   <= id_ex.mem_read;
			ex_mem.mem_write  <= id_ex.mem_write;
			ex_mem.wb_sel     <= id_ex.wb_sel;
			ex_mem.reg_write  <= id_ex.reg_write;
			ex_mem.pc_plus4   <= id_ex.pc_plus4;
		end
	end

endmodule

//--- logic/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
	input  logic            clk,
	input  logic            rst,
	input  logic            redirect,
	input  mips_pkg::word_t target,
	output mips_pkg::word_t instr,
	output mips_pkg::word_t pc_plus4
);
	import mips_pkg::*;

	word_t pc;
	word_t seq_pc;
	// instruction rom
	word_t imem [IMEM_WORDS];

	initial begin
		$readmemh(IMEM_FILE, imem);
	end

	assign seq_pc = pc + XLEN'(4);

	// ############################################################
	// pc and fetch/decode register
	// ############################################################
	always_ff @(posedge clk) begin
		if (rst) begin
			pc       <= '0;
			instr    <= '0;
			pc_plus4 <= '0;
		end else begin
			// decode owns redirect, target wins over pc + 4
			pc       <= redirect ? target : seq_pc;
			// flush the wrong-path fetch into an all-zero bubble
			instr    <= redirect ? '0 : imem[pc[IMEM_AW+1:2]];
			pc_plus4 <= seq_pc;
		end
	end

endmodule

//--- logic/memory_unit.sv
`timescale 1ns/1ps

module memory_unit (
	input  logic            clk,
	input  logic            rst,
	ex_mem_if.dst           ex_mem,
	mem_wb_if.src           mem_wb,
	output mips_pkg::word_t out1,
	output mips_pkg::word_t out2
);
	import mips_pkg::*;

	word_t              dmem [DMEM_WORDS];
	logic [DMEM_AW-1:0] dmem_addr;

	// word index, byte offset ignored
	assign dmem_addr = ex_mem.alu_result[DMEM_AW+1:2];

	// store lands at end of the memory cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < DMEM_WORDS; i++) begin
				dmem[i] <= '0;
			end
		end else if (ex_mem.mem_write) begin
			dmem[dmem_addr] <= ex_mem.store_data;
		end
	end

	// observation words
	assign out1 = dmem[0];
	assign out2 = dmem[1];

	// memory/writeback register
	always_ff @(posedge clk) begin
		if (rst) begin
			mem_wb.alu_result <= '0;
			mem_wb.mem_data   <= '0;
			mem_wb.dest       <= '0;
			mem_wb.wb_sel     <= WB_ALU;
			mem_wb.reg_write  <= 1'b0;
			mem_wb.pc_plus4   <= '0;
		end else begin
			mem_wb.alu_result <= ex_mem.alu_result;
			// only loads sample the array
			mem_wb.mem_data   <= ex_mem.mem_read ? dmem[dmem_addr] : '0;
			mem_wb.dest       <= ex_mem.dest;
			mem_wb.wb_sel     <= ex_mem.wb_sel;
			mem_wb.reg_write  <= ex_mem.reg_write;
			mem_wb.pc_plus4   <= ex_mem.pc_plus4;
		end
	end

endmodule

//--- logic/mips.sv
`timescale 1ns/1ps

module mips (
	input  logic            clk,
	input  logic            rst,
	output mips_pkg::word_t out1,
	output mips_pkg::word_t out2
);
	import mips_pkg::*;

	// fetch/decode link
	word_t instr;
	word_t pc_plus4;
	logic  redirect;
	word_t target;

	// ############################################################
	// stage boundaries
	// ############################################################
	id_ex_if  id_ex ();
	ex_mem_if ex_mem ();
	mem_wb_if mem_wb ();

	fetch_unit u_fetch (
		.clk      (clk),
		.rst      (rst),
		.redirect (redirect),
		.target   (target),
		.instr    (instr),
		.pc_plus4 (pc_plus4)
	);

	// decode also hosts writeback
	decode_unit u_decode (
		.clk      (clk),
		.rst      (rst),
		.instr    (instr),
		.pc_plus4 (pc_plus4),
		.redirect (redirect),
		.target   (target),
		.id_ex    (id_ex),
		.mem_wb   (mem_wb)
	);

	execute_unit u_execute (
		.clk    (clk),
		.rst    (rst),
		.id_ex  (id_ex),
		.ex_mem (ex_mem)
	);

	memory_unit u_memory (
		.clk    (clk),
		.rst    (rst),
		.ex_mem (ex_mem),
		.mem_wb (mem_wb),
		.out1   (out1),
		.out2   (out2)
	);

endmodule

//--- logic/mips_pkg.sv
package mips_pkg;

	// ############################################################
	// widths and sizes
	// ############################################################
	localparam int XLEN       = 32;
	localparam int REG_AW     = 5;
	localparam int SHAMT_W    = 5;
	localparam int IMEM_WORDS = 64;
	localparam int DMEM_WORDS = 64;
	// word index widths, byte offset dropped
	localparam int IMEM_AW    = $clog2(IMEM_WORDS);
	localparam int DMEM_AW    = $clog2(DMEM_WORDS);

	localparam string IMEM_FILE = "program.hex";
	// jal return address lands here
	localparam int LINK_REG = 31;

	typedef logic [XLEN-1:0]   word_t;
	typedef logic [REG_AW-1:0] reg_idx_t;

	// ############################################################
	// encodings
	// ############################################################
	// primary opcode, instr[31:26]
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J     = 6'h02,
		OP_JAL   = 6'h03,
		OP_BEQ   = 6'h04,
		OP_BNE   = 6'h05,
		OP_ADDI  = 6'h08,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_t;

	// r-type function, instr[5:0]
	typedef enum logic [5:0] {
		FN_SLL = 6'h00,
		FN_JR  = 6'h08,
		FN_ADD = 6'h20,
		FN_SUB = 6'h22,
		FN_AND = 6'h24,
		FN_OR  = 6'h25,
		FN_SLT = 6'h2a
	} funct_t;

	typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_SLL} alu_op_t;
	typedef enum logic [1:0] {DST_RT, DST_RD, DST_RA} dst_sel_t;
	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wb_sel_t;
	// branches stay PC_SEQ here, taken branches come from the compare
	typedef enum logic [1:0] {PC_SEQ, PC_JUMP, PC_REG} pc_sel_t;

endpackage

//--- logic/pipe_if.sv
`timescale 1ns/1ps

// decode -> execute stage boundary
interface id_ex_if;
	import mips_pkg::*;
	// operands
	word_t             rs_val;
	word_t             rt_val;
	word_t             imm;
	logic [SHAMT_W-1:0] shamt;
	// destination candidates
	reg_idx_t          rt;
	reg_idx_t          rd;
	// control
	alu_op_t           alu_op;
	logic              use_imm;
	logic              use_shamt;
	dst_sel_t          dst_sel;
	logic              mem_read;
	logic              mem_write;
	wb_sel_t           wb_sel;
	logic              reg_write;
	word_t             pc_plus4;

	modport src (output rs_val, rt_val, imm, shamt, rt, rd, alu_op, use_imm, use_shamt,
		dst_sel, mem_read, mem_write, wb_sel, reg_write, pc_plus4);
	modport dst (input rs_val, rt_val, imm, shamt, rt, rd, alu_op, use_imm, use_shamt,
		dst_sel, mem_read, mem_write, wb_sel, reg_write, pc_plus4);
endinterface

// execute -> memory stage boundary
interface ex_mem_if;
	import mips_pkg::*;
	word_t    alu_result;
	word_t    store_data;
	reg_idx_t dest;
	logic     mem_read;
	logic     mem_write;
	wb_sel_t  wb_sel;
	logic     reg_write;
	word_t    pc_plus4;

	modport src (output alu_result, store_data, dest, mem_read, mem_write, wb_sel,
		reg_write, pc_plus4);
	modport dst (input alu_result, store_data, dest, mem_read, mem_write, wb_sel,
		reg_write, pc_plus4);
endinterface

// memory -> writeback, consumed by the register file in decode
interface mem_wb_if;
	import mips_pkg::*;
	word_t    alu_result;
	word_t    mem_data;
	reg_idx_t dest;
	wb_sel_t  wb_sel;
	logic     reg_write;
	word_t    pc_plus4;

	modport src (output alu_result, mem_data, dest, wb_sel, reg_write, pc_plus4);
	modport dst (input alu_result, mem_data, dest, wb_sel, reg_write, pc_plus4);
endinterface

//--- logic/register_file.sv
`timescale 1ns/1ps

module register_file (
	input  logic               clk,
	input  logic               rst,
	input  logic               we,
	input  mips_pkg::reg_idx_t waddr,
	input  mips_pkg::word_t    wdata,
	input  mips_pkg::reg_idx_t raddr_a,
	input  mips_pkg::reg_idx_t raddr_b,
	output mips_pkg::word_t    rdata_a,
	output mips_pkg::word_t    rdata_b
);
	import mips_pkg::*;

	word_t regs [2**REG_AW];

	// written at end of writeback, no bypass to decode
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 2**REG_AW; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// r0 hardwired
	assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
	assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

//--- program.hex
// one 32-bit instruction word per line in hex, first line at byte address 0
// text after the word is the assembly of that word
2001000c // addi r1, r0, 12
20020005 // addi r2, r0, 5
2003fff9 // addi r3, r0, -7
200a0040 // addi r10, r0, 64
00000000 // nop
00222020 // add  r4, r1, r2
00232822 // sub  r5, r1, r3
00223024 // and  r6, r1, r2
00223825 // or   r7, r1, r2
ac040000 // sw   r4, 0(r0)
ac050000 // sw   r5, 0(r0)
ac060000 // sw   r6, 0(r0)
ac070000 // sw   r7, 0(r0)
0061402a // slt  r8, r3, r1
00024900 // sll  r9, r2, 4
202b0064 // addi r11, r1, 100
ad440000 // sw   r4, 0(r10)
ac080000 // sw   r8, 0(r0)
ac090000 // sw   r9, 0(r0)
ac0b0000 // sw   r11, 0(r0)
8d4c0000 // lw   r12, 0(r10)
10220001 // beq  r1, r2, +1   not taken
14210001 // bne  r1, r1, +1   not taken
200d0007 // addi r13, r0, 7
ac0c0004 // sw   r12, 4(r0)
10210001 // beq  r1, r1, +1   taken
ac000000 // sw   r0, 0(r0)    flushed
14220001 // bne  r1, r2, +1   taken
ac000000 // sw   r0, 0(r0)    flushed
0800001f // j    31
ac000004 // sw   r0, 4(r0)    jumped over
0c000023 // jal  35
ac0d0000 // sw   r13, 0(r0)   return point of jr
ac0e0000 // sw   r14, 0(r0)
08000022 // j    34           self-jump, end of program
200e0009 // addi r14, r0, 9
00000000 // nop
ac1f0004 // sw   r31, 4(r0)
03e00008 // jr   r31
ac000004 // sw   r0, 4(r0)    flushed
